// ==== testbench/bp_cases.txt ====
# op btb_target taken jump exe_target exp_prediction exp_mispredicted
# op P predict, S predict under stall, E execute, F flush with execute; prediction checked on P/S
# Reset state predicts not taken and a matching not-taken execute is correct
P 00000100 0 0 00000100 0 0
E 00000100 0 0 00000100 0 0
# Targets chosen so every lookup lands on counter 5 while the history moves
P 00000105 0 0 00000105 0 0
E 00000105 1 0 00000105 0 1
P 00000104 0 0 00000104 0 0
E 00000104 1 0 00000104 0 1
P 00000106 0 0 00000106 1 0
E 00000106 1 0 00000106 0 0
P 00000102 0 0 00000102 1 0
E 00000102 1 0 00000102 0 0
P 0000010a 0 0 0000010a 1 0
E 0000010a 0 0 0000010a 0 1
P 0000010b 0 0 0000010b 1 0
E 0000010b 0 0 0000010b 0 1
P 00000109 0 0 00000109 0 0
E 00000109 0 0 00000109 0 0
# Direction mismatch clears the second record, the next execute finds nothing
P 00000300 0 0 00000300 0 0
P 00000304 0 0 00000304 0 0
E 00000300 1 0 00000300 0 1
E 00000304 0 0 00000304 0 0
# Jumps train counter 6 up, then a wrong jump target mispredicts with direction right
P 00000404 0 0 00000404 0 0
E 00000404 0 1 00000404 0 1
P 00000413 0 0 00000413 0 0
E 00000413 0 1 00000413 0 1
P 0000042d 0 0 0000042d 1 0
E 0000042d 0 1 00000500 0 1
# Flush hides a wrong direction and empties the queue
P 00000600 0 0 00000600 0 0
F 00000600 1 0 00000600 0 0
E 00000600 0 0 00000600 0 0
# Three records in flight resolve in order, the stalled predict is never queued
P 00000708 0 0 00000708 1 0
S 000007ff 0 0 000007ff 0 0
P 00000710 0 0 00000710 0 0
P 00000723 0 0 00000723 0 0
E 00000708 0 1 00000708 0 0
E 00000710 0 0 00000710 0 0
E 00000723 0 0 00000723 0 0

// ==== sources.f ====
logic/bp_config_pkg.sv
logic/bp_record_pkg.sv
logic/bp_global_history.sv
logic/bp_pattern_table.sv
logic/bp_pending_queue.sv
logic/bp_control.sv
logic/gshare_predictor.sv
testbench/tb_gshare_predictor.sv

// ==== Bender.yml ====
package:
  name: gshare_predictor

sources:
  - logic/bp_config_pkg.sv
  - logic/bp_record_pkg.sv
  - logic/bp_global_history.sv
  - logic/bp_pattern_table.sv
  - logic/bp_pending_queue.sv
  - logic/bp_control.sv
  - logic/gshare_predictor.sv
  - target: test
    files:
      - testbench/tb_gshare_predictor.sv

// ==== testbench/tb_gshare_predictor.sv ====
// Testbench for the gshare predictor that replays testbench/bp_cases.txt and checks both outputs
`timescale 1ns/1ps

module tb_gshare_predictor import bp_config_pkg::*, bp_record_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_ROWS     = 128;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        flush;
    bp_request_t req;
    bp_resolve_t res;
    logic        prediction;
    logic        mispredicted;

    // One entry per case row, all filled at time zero
    logic [7:0]  row_op       [MAX_ROWS];
    bp_addr_t    row_btb      [MAX_ROWS];
    logic        row_taken    [MAX_ROWS];
    logic        row_jump     [MAX_ROWS];
    bp_addr_t    row_exe      [MAX_ROWS];
    logic        row_exp_pred [MAX_ROWS];
    logic        row_exp_mis  [MAX_ROWS];

    int num_rows     = 0;
    int error_count  = 0;
    int check_count  = 0;
    bit cases_loaded = 1'b0;

    // A small table of 16 counters so that short case rows reach aliasing
    gshare_predictor #(
        .TABLE_SIZE  (16),
        .QUEUE_DEPTH (8)
    ) u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .stall_i        (stall),
        .flush_i        (flush),
        .req_i          (req),
        .res_i          (res),
        .prediction_o   (prediction),
        .mispredicted_o (mispredicted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================================
    // Case file reading
    // ==================================================================

    // Rows hold an operation letter and six fields, lines starting with # are skipped
    task automatic load_cases();
        int         fd;
        int         code;
        int         ch;
        logic [7:0] op;
        bp_addr_t   btb;
        bp_addr_t   exe;
        logic       taken;
        logic       jump;
        logic       exp_pred;
        logic       exp_mis;
        bit         done;
        fd = $fopen("testbench/bp_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/bp_cases.txt for reading");
            error_count++;
            return;
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%h %b %b %h %b %b", btb, taken, jump, exe,
                               exp_pred, exp_mis);
                if (code != 6 || num_rows == MAX_ROWS) begin
                    $display("Case row %0d is malformed or past the row limit", num_rows + 1);
                    error_count++;
                    done = 1'b1;
                end else begin
                    row_op[num_rows]       = op;
                    row_btb[num_rows]      = btb;
                    row_taken[num_rows]    = taken;
                    row_jump[num_rows]     = jump;
                    row_exe[num_rows]      = exe;
                    row_exp_pred[num_rows] = exp_pred;
                    row_exp_mis[num_rows]  = exp_mis;
                    num_rows++;
                end
            end
        end
        $fclose(fd);
        cases_loaded = 1'b1;
    endtask

    // ==================================================================
    // Driving and checking
    // ==================================================================

    // P predicts, S predicts under stall, E executes, F flushes while a branch executes
    task automatic drive_row(input int r);
        logic is_predict;
        logic is_execute;
        is_predict = (row_op[r] == "P") || (row_op[r] == "S");
        is_execute = (row_op[r] == "E") || (row_op[r] == "F");
        if (!is_predict && !is_execute) begin
            $display("Case row %0d has an unknown operation letter", r + 1);
            error_count++;
        end
        req.predict  <= is_predict;
        req.target   <= row_btb[r];
        stall        <= (row_op[r] == "S");
        flush        <= (row_op[r] == "F");
        res.executed <= is_execute;
        res.taken    <= row_taken[r];
        res.jump     <= row_jump[r];
        res.target   <= row_exe[r];
    endtask

    task automatic compare_bit(input string what, input int r, input logic actual,
                               input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0d ns: case %0d %s is %b, expected %b", $time, r + 1, what,
                     actual, expected);
        end
    endtask

    initial begin : stimulus
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        req   = '0;
        res   = '0;
        load_cases();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        if (cases_loaded) begin
            for (int r = 0; r < num_rows; r++) begin
                @(posedge clk);
                drive_row(r);
                // Both outputs are combinational and have settled by the falling edge
                @(negedge clk);
                if (row_op[r] == "P" || row_op[r] == "S") begin
                    compare_bit("prediction_o", r, prediction, row_exp_pred[r]);
                end
                compare_bit("mispredicted_o", r, mispredicted, row_exp_mis[r]);
            end
        end
        @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b0;
        req   <= '0;
        res   <= '0;
        @(negedge clk);
        $display("Cases: %0d, checks: %0d, errors: %0d", num_rows, check_count, error_count);
        if (cases_loaded && check_count > 0 && error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // One cycle per case row, with spare cycles for reset and the closing idle cycle
    initial begin : watchdog
        wait (cases_loaded);
        #((num_rows + 20) * CLK_PERIOD);
        $display("Timeout: the case file did not finish within %0d clock cycles",
                 num_rows + 20);
        $display("test failed");
        $finish;
    end

endmodule : tb_gshare_predictor

// ==== logic/gshare_predictor.sv ====
// Top level of the gshare branch predictor that joins history, counter table, queue and control
`timescale 1ns/1ps

module gshare_predictor import bp_config_pkg::*, bp_record_pkg::*; #(
    parameter int TABLE_SIZE  = 1024,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  bp_request_t req_i,
    input  bp_resolve_t res_i,
    output logic        prediction_o,
    output logic        mispredicted_o
);

    bp_index_t   lookup_index;
    bp_counter_t lookup_counter;
    bp_record_t  head;
    logic        empty;
    logic        push;
    bp_record_t  push_record;
    logic        pull;
    logic        clear;
    logic        train;
    logic        shift;
    logic        outcome;

    bp_global_history #(.TABLE_SIZE(TABLE_SIZE)) u_history (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .shift_i   (shift),
        .outcome_i (outcome),
        .target_i  (req_i.target),
        .index_o   (lookup_index)
    );

    // The train counter output is a debug view and stays open here
    bp_pattern_table #(.TABLE_SIZE(TABLE_SIZE)) u_table (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .lookup_index_i   (lookup_index),
        .lookup_counter_o (lookup_counter),
        .train_i          (train),
        .train_index_i    (head.index),
        .train_taken_i    (outcome),
        .train_counter_o  ()
    );

    bp_pending_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .push_i        (push),
        .push_record_i (push_record),
        .pull_i        (pull),
        .clear_i       (clear),
        .head_o        (head),
        .empty_o       (empty)
    );

    bp_control u_control (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .req_i            (req_i),
        .res_i            (res_i),
        .lookup_counter_i (lookup_counter),
        .lookup_index_i   (lookup_index),
        .head_i           (head),
        .empty_i          (empty),
        .push_o           (push),
        .push_record_o    (push_record),
        .pull_o           (pull),
        .clear_o          (clear),
        .train_o          (train),
        .shift_o          (shift),
        .outcome_o        (outcome),
        .prediction_o     (prediction_o),
        .mispredicted_o   (mispredicted_o)
    );

endmodule : gshare_predictor

// ==== logic/bp_control.sv ====
// Predictor control that forms the prediction and decides push, pull, training and misprediction
`timescale 1ns/1ps

module bp_control import bp_config_pkg::*, bp_record_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  bp_request_t req_i,
    input  bp_resolve_t res_i,
    input  bp_counter_t lookup_counter_i,
    input  bp_index_t   lookup_index_i,
    input  bp_record_t  head_i,
    input  logic        empty_i,
    output logic        push_o,
    output bp_record_t  push_record_o,
    output logic        pull_o,
    output logic        clear_o,
    output logic        train_o,
    output logic        shift_o,
    output logic        outcome_o,
    output logic        prediction_o,
    output logic        mispredicted_o
);

    // ==================================================================
    // Prediction side
    // ==================================================================

    // Upper half of the counter range predicts taken
    assign prediction_o = lookup_counter_i[1];

    // A stalled fetch repeats its request later, so it is not recorded now
    assign push_o = req_i.predict && !stall_i;

    // The record keeps the slot that was read so training hits the same counter
    assign push_record_o = '{predicted: prediction_o,
                             index:     lookup_index_i,
                             target:    req_i.target};

    // ==================================================================
    // Resolution side
    // ==================================================================

    // Jumps count as taken branches
    assign outcome_o = res_i.taken || res_i.jump;

    assign pull_o = res_i.executed && !empty_i;

    // Training and history follow every executed branch
    assign train_o = res_i.executed;
    assign shift_o = res_i.executed;

    // Wrong direction, or a register-indirect target that the BTB got wrong
    assign mispredicted_o = res_i.executed && !empty_i && !flush_i &&
                            ((outcome_o != head_i.predicted) ||
                             (head_i.target != res_i.target));

    // Everything younger than a wrong prediction was fetched down the wrong path
    assign clear_o = mispredicted_o || flush_i;

    a_no_rise_on_flush : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |-> !$rose(mispredicted_o))
        else $error("Misprediction raised during a flush");

endmodule : bp_control

// ==== logic/bp_pending_queue.sv ====
// Circular queue of in-flight prediction records, read in order as branches execute
`timescale 1ns/1ps

module bp_pending_queue import bp_config_pkg::*, bp_record_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       push_i,
    input  bp_record_t push_record_i,
    input  logic       pull_i,
    input  logic       clear_i,
    output bp_record_t head_o,
    output logic       empty_o
);

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    bp_record_t slots [QUEUE_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_next;
    logic [PTR_BITS-1:0] rd_next;
    logic                full;

    // ==================================================================
    // Pointers and occupancy
    // ==================================================================

    // Pointers wrap at the last slot so any depth works
    assign wr_next = (wr_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign rd_next = (rd_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

    // Equal pointers mean full unless the empty flag says otherwise
    assign full = !empty_o && (wr_ptr == rd_ptr);

    // A clear drops every record, including one pushed in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            empty_o <= 1'b1;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_next;
            end
            if (pull_i) begin
                rd_ptr <= rd_next;
            end
            // Push together with pull keeps the occupancy unchanged
            case ({push_i, pull_i})
                2'b10:   empty_o <= 1'b0;
                2'b01:   empty_o <= (rd_next == wr_ptr);
                default: empty_o <= empty_o;
            endcase
        end
    end

    // ==================================================================
    // Record storage
    // ==================================================================

    always_ff @(posedge clk_i) begin
        if (push_i && !clear_i) begin
            slots[wr_ptr] <= push_record_i;
        end
    end

    // The oldest record is always visible for the resolve compare
    assign head_o = slots[rd_ptr];

    a_no_pull_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
        pull_i |-> !empty_o)
        else $error("Pull from an empty prediction queue");

    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
        (push_i && !pull_i) |-> !full)
        else $error("Push into a full prediction queue");

endmodule : bp_pending_queue

// ==== logic/bp_pattern_table.sv ====
// Table of 2-bit saturating counters with a lookup port for fetch and a train port for execution
`timescale 1ns/1ps

module bp_pattern_table import bp_config_pkg::*; #(
    parameter int TABLE_SIZE = 1024
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    // Lookup port, read combinationally for the prediction
    input  bp_index_t   lookup_index_i,
    output bp_counter_t lookup_counter_o,
    // Train port, the slot of the oldest queued prediction
    input  logic        train_i,
    input  bp_index_t   train_index_i,
    input  logic        train_taken_i,
    output bp_counter_t train_counter_o
);

    localparam int INDEX_BITS = $clog2(TABLE_SIZE);

    bp_counter_t counters [TABLE_SIZE];

    logic [INDEX_BITS-1:0] lookup_slot;
    logic [INDEX_BITS-1:0] train_slot;
    bp_counter_t           train_next;

    // Only the low index bits select a slot
    assign lookup_slot = lookup_index_i[INDEX_BITS-1:0];
    assign train_slot  = train_index_i[INDEX_BITS-1:0];

    // ==================================================================
    // Read ports
    // ==================================================================

    // A write in the same cycle lands at the edge, so the lookup sees the old value
    assign lookup_counter_o = counters[lookup_slot];
    assign train_counter_o  = counters[train_slot];

    // ==================================================================
    // Saturating update
    // ==================================================================

    // Step one toward the real outcome and hold at either end
    always_comb begin
        if (train_taken_i) begin
            train_next = (train_counter_o == 2'd3) ? train_counter_o : train_counter_o + 2'd1;
        end else begin
            train_next = (train_counter_o == 2'd0) ? train_counter_o : train_counter_o - 2'd1;
        end
    end

    // Reset walks the whole array back to strongly not taken
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                counters[i] <= BP_COUNTER_RESET;
            end
        end else if (train_i) begin
            counters[train_slot] <= train_next;
        end
    end

    // Training must land inside the table, the upper index bits stay zero
    a_train_index : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        train_i |-> (train_index_i < TABLE_SIZE))
        else $error("Training index %0d outside table of %0d", train_index_i, TABLE_SIZE);

endmodule : bp_pattern_table

// ==== logic/bp_global_history.sv ====
// Global branch history shift register that hashes the history with a target into a table index
`timescale 1ns/1ps

module bp_global_history import bp_config_pkg::*; #(
    parameter int TABLE_SIZE = 1024
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      shift_i,
    input  logic      outcome_i,
    input  bp_addr_t  target_i,
    output bp_index_t index_o
);

    // One history bit per index bit of the counter table
    localparam int HIST_BITS = $clog2(TABLE_SIZE);

    logic [HIST_BITS-1:0] history;
    // History with the new outcome appended at the low end
    logic [HIST_BITS:0]   history_ext;

    assign history_ext = {history, outcome_i};

    // The newest outcome enters at bit 0 and the oldest one drops off the top
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            history <= '0;
        end else if (shift_i) begin
            history <= history_ext[HIST_BITS-1:0];
        end
    end

    // Gshare hash of history and low target bits, zero extended to the index width
    assign index_o = bp_index_t'(history ^ target_i[HIST_BITS-1:0]);

    // The table size must be a power of two whose index fits the shared index type
    a_table_size : assert property (@(posedge clk_i)
        (TABLE_SIZE >= 2) && ((TABLE_SIZE & (TABLE_SIZE - 1)) == 0) &&
        (HIST_BITS <= BP_MAX_INDEX_BITS))
        else $error("TABLE_SIZE %0d is not a usable power of two", TABLE_SIZE);

endmodule : bp_global_history

// ==== logic/bp_record_pkg.sv ====
// Packed structs for prediction requests, branch resolutions and queued prediction records
package bp_record_pkg;

    import bp_config_pkg::*;

    // Request from fetch when the BTB hits on the current fetch address
    // Total width is 33 bits
    typedef struct packed {
        // Strobe that asks for a prediction in this cycle
        logic     predict;
        // Target address that the BTB returned for this branch
        bp_addr_t target;
    } bp_request_t;

    // Resolution from the execution unit for the oldest branch in flight
    // Total width is 35 bits
    typedef struct packed {
        // Strobe that marks a branch leaving execution in this cycle
        logic     executed;
        // Conditional branch condition evaluated true
        logic     taken;
        // Unconditional jump, which always counts as taken
        logic     jump;
        // Target address computed by the execution unit
        bp_addr_t target;
    } bp_resolve_t;

    // One prediction waiting for its branch to execute
    // Total width is 49 bits
    typedef struct packed {
        // Direction handed to fetch when the prediction was made
        logic      predicted;
        // Counter slot that was read, and that training will update
        bp_index_t index;
        // BTB target, compared later against the computed target
        bp_addr_t  target;
    } bp_record_t;

endpackage : bp_record_pkg

// ==== logic/bp_config_pkg.sv ====
// Sizes, address and counter types shared by every block of the gshare predictor
package bp_config_pkg;

    // ==================================================================
    // Addresses
    // ==================================================================

    // Instruction address as seen by fetch and the execution unit
    typedef logic [31:0] bp_addr_t;

    // ==================================================================
    // Counter table indexing
    // ==================================================================

    // Widest counter index that any table size may need
    localparam int BP_MAX_INDEX_BITS = 16;

    // Index fields carry the full width; each block uses only the low bits
    // that its own table size needs
    typedef logic [BP_MAX_INDEX_BITS-1:0] bp_index_t;

    // ==================================================================
    // Saturating counters
    // ==================================================================

    // Values 0 and 1 predict not taken, values 2 and 3 predict taken
    typedef logic [1:0] bp_counter_t;

    // Every counter starts out strongly not taken
    localparam bp_counter_t BP_COUNTER_RESET = 2'd0;

endpackage : bp_config_pkg
